/* common/cpuPkg.sv */
package cpuPkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int pcWidth = 22;
	localparam int immWidth = 17;
	localparam int opcodeWidth = 5;
	localparam int aluOpWidth = 4;
	localparam int wbSelWidth = 3;     // five write-back sources
	localparam int pcSelWidth = 2;
	localparam int switchCount = 18;
	localparam int buttonCount = 4;

	// --------------------------------------------------
	// opcodes
	// --------------------------------------------------
	localparam logic [opcodeWidth-1:0] opAdd = 5'b00000;
	localparam logic [opcodeWidth-1:0] opAddI = 5'b00001;
	localparam logic [opcodeWidth-1:0] opSub = 5'b00010;
	localparam logic [opcodeWidth-1:0] opSubI = 5'b00011;
	localparam logic [opcodeWidth-1:0] opMult = 5'b00100;
	localparam logic [opcodeWidth-1:0] opMultI = 5'b00101;
	localparam logic [opcodeWidth-1:0] opAnd = 5'b00110;
	localparam logic [opcodeWidth-1:0] opAndI = 5'b00111;
	localparam logic [opcodeWidth-1:0] opOr = 5'b01000;
	localparam logic [opcodeWidth-1:0] opOrI = 5'b01001;
	localparam logic [opcodeWidth-1:0] opNot = 5'b01010;
	localparam logic [opcodeWidth-1:0] opSlt = 5'b01011;
	localparam logic [opcodeWidth-1:0] opSltI = 5'b01100;
	localparam logic [opcodeWidth-1:0] opSll = 5'b01101;
	localparam logic [opcodeWidth-1:0] opSlr = 5'b01110;
	localparam logic [opcodeWidth-1:0] opMove = 5'b01111;
	localparam logic [opcodeWidth-1:0] opJ = 5'b10000;
	localparam logic [opcodeWidth-1:0] opJr = 5'b10001;
	localparam logic [opcodeWidth-1:0] opBeq = 5'b10011;
	localparam logic [opcodeWidth-1:0] opBnq = 5'b10100;
	localparam logic [opcodeWidth-1:0] opLoad = 5'b10111;
	localparam logic [opcodeWidth-1:0] opStore = 5'b11000;
	localparam logic [opcodeWidth-1:0] opInput = 5'b11001;
	localparam logic [opcodeWidth-1:0] opOutput = 5'b11010;
	localparam logic [opcodeWidth-1:0] opSetR = 5'b11011;
	localparam logic [opcodeWidth-1:0] opEnd = 5'b11111;

	// --------------------------------------------------
	// select codes
	// --------------------------------------------------
	localparam logic [aluOpWidth-1:0] aluAdd = 4'd0;
	localparam logic [aluOpWidth-1:0] aluSub = 4'd1;
	localparam logic [aluOpWidth-1:0] aluMult = 4'd2;
	localparam logic [aluOpWidth-1:0] aluAnd = 4'd3;
	localparam logic [aluOpWidth-1:0] aluOr = 4'd4;
	localparam logic [aluOpWidth-1:0] aluNot = 4'd5;
	localparam logic [aluOpWidth-1:0] aluSll = 4'd6;
	localparam logic [aluOpWidth-1:0] aluSlr = 4'd7;
	localparam logic [aluOpWidth-1:0] aluEq = 4'd8;
	localparam logic [aluOpWidth-1:0] aluNe = 4'd9;
	localparam logic [aluOpWidth-1:0] aluLt = 4'd11;

	localparam logic [wbSelWidth-1:0] wbMem = 3'd0;
	localparam logic [wbSelWidth-1:0] wbAlu = 3'd1;
	localparam logic [wbSelWidth-1:0] wbMove = 3'd2;
	localparam logic [wbSelWidth-1:0] wbInput = 3'd3;
	localparam logic [wbSelWidth-1:0] wbLong = 3'd4;

	localparam logic [pcSelWidth-1:0] pcStep = 2'd0;
	localparam logic [pcSelWidth-1:0] pcJump = 2'd1;
	localparam logic [pcSelWidth-1:0] pcBranch = 2'd2;
	localparam logic [pcSelWidth-1:0] pcReg = 2'd3;

	// one word, two field layouts
	typedef union packed {
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regAddrWidth-1:0] ra;
			logic [regAddrWidth-1:0] rb;
			logic [regAddrWidth-1:0] rc;
			logic [11:0] unused;
		} regForm;
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regAddrWidth-1:0] ra;
			logic [pcWidth-1:0] target;   // short immediate is the low 17 bits
		} longForm;
	} instrWord;

endpackage

/* core/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic [opcodeWidth-1:0] opcode,
	output logic regWrite,
	output logic memWrite,
	output logic portWrite,
	output logic useImm,
	output logic readRc,
	output logic [aluOpWidth-1:0] aluOp,
	output logic [wbSelWidth-1:0] wbSel,
	output logic [pcSelWidth-1:0] pcSel,
	output logic holdPc,
	output logic clearPc,
	output logic halted
);
	logic started;

	always_ff @(posedge clk)
	begin
		if (rst)
			started <= 1'b0;
		else if (run)
			started <= 1'b1;     // stays set until the next reset
	end

	assign clearPc = !started;
	assign halted = started && (opcode == opEnd);
	assign holdPc = halted;

	// --------------------------------------------------
	// ALU operation per opcode
	// --------------------------------------------------
	always_comb
	begin
		case (opcode)
			opSub, opSubI: aluOp = aluSub;
			opMult, opMultI: aluOp = aluMult;
			opAnd, opAndI: aluOp = aluAnd;
			opOr, opOrI: aluOp = aluOr;
			opNot: aluOp = aluNot;
			opSll: aluOp = aluSll;
			opSlr: aluOp = aluSlr;
			opSlt, opSltI: aluOp = aluLt;
			opBeq: aluOp = aluEq;
			opBnq: aluOp = aluNe;
			default: aluOp = aluAdd;
		endcase
	end

	// --------------------------------------------------
	// strobes and selects
	// --------------------------------------------------
	always_comb
	begin
		regWrite = 1'b0;
		memWrite = 1'b0;
		portWrite = 1'b0;
		useImm = 1'b0;
		readRc = 1'b0;         // second source is ra unless register form
		wbSel = wbAlu;
		pcSel = pcStep;
		if (started)
		begin
			case (opcode)
				opAdd, opSub, opMult, opAnd, opOr, opSlt:
				begin
					regWrite = 1'b1;
					readRc = 1'b1;
				end
				opAddI, opSubI, opMultI, opAndI, opOrI, opSltI:
				begin
					regWrite = 1'b1;
					useImm = 1'b1;
				end
				opNot, opSll, opSlr: regWrite = 1'b1;
				opMove:
				begin
					regWrite = 1'b1;
					wbSel = wbMove;
				end
				opLoad:
				begin
					regWrite = 1'b1;
					wbSel = wbMem;
				end
				opInput:
				begin
					regWrite = 1'b1;
					wbSel = wbInput;
				end
				opSetR:
				begin
					regWrite = 1'b1;
					wbSel = wbLong;
				end
				opStore: memWrite = 1'b1;
				opOutput: portWrite = 1'b1;
				opJ: pcSel = pcJump;
				opJr: pcSel = pcReg;
				opBeq, opBnq: pcSel = pcBranch;
				default: ;             // END and unused opcodes write nothing
			endcase
		end
	end

endmodule

/* core/alu.sv */
`timescale 1ns/100ps

module alu import cpuPkg::*;
(
	input  logic [aluOpWidth-1:0] aluOp,
	input  logic useImm,
	input  logic [dataWidth-1:0] regA,
	input  logic [dataWidth-1:0] regB,
	input  logic [immWidth-1:0] imm,
	output logic [dataWidth-1:0] aluResult
);
	logic signed [dataWidth-1:0] opA;
	logic signed [dataWidth-1:0] opB;

	assign opA = regA;
	assign opB = useImm ? {{(dataWidth-immWidth){1'b0}}, imm} : regB;   // zero-extended

	always_comb
	begin
		case (aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluMult: aluResult = opA * opB;        // low word only
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluNot: aluResult = ~opA;
			aluSll: aluResult = opA << 1;
			aluSlr: aluResult = opA >> 1;          // logical
			aluEq: aluResult = {{(dataWidth-1){1'b0}}, opA == opB};
			aluNe: aluResult = {{(dataWidth-1){1'b0}}, opA != opB};
			aluLt: aluResult = {{(dataWidth-1){1'b0}}, opA < opB};   // signed
			default: aluResult = '0;
		endcase
	end

endmodule

/* core/registerFile.sv */
`timescale 1ns/100ps

module registerFile import cpuPkg::*;
(
	input  logic clk,
	input  logic regWrite,
	input  logic [wbSelWidth-1:0] wbSel,
	input  logic [regAddrWidth-1:0] writeAddr,
	input  logic [regAddrWidth-1:0] readAddrA,
	input  logic [regAddrWidth-1:0] readAddrB,
	input  logic [dataWidth-1:0] memData,
	input  logic [dataWidth-1:0] aluResult,
	input  logic [dataWidth-1:0] inputData,
	input  logic [pcWidth-1:0] longImm,
	output logic [dataWidth-1:0] regA,
	output logic [dataWidth-1:0] regB
);
	logic [dataWidth-1:0] regs [1 << regAddrWidth];
	logic [dataWidth-1:0] writeData;

	always_comb
	begin
		case (wbSel)
			wbMem: writeData = memData;
			wbMove: writeData = regA;                  // MOVE copies rb
			wbInput: writeData = inputData;
			wbLong: writeData = {{(dataWidth-pcWidth){1'b0}}, longImm};
			default: writeData = aluResult;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (regWrite)
			regs[writeAddr] <= writeData;
	end

	assign regA = regs[readAddrA];
	assign regB = regs[readAddrB];

endmodule

/* core/nextPc.sv */
`timescale 1ns/100ps

module nextPc import cpuPkg::*;
(
	input  logic clk,
	input  logic clearPc,
	input  logic holdPc,
	input  logic [pcSelWidth-1:0] pcSel,
	input  logic [pcWidth-1:0] target,
	input  logic [immWidth-1:0] imm,
	input  logic [dataWidth-1:0] regA,
	input  logic taken,
	output logic [pcWidth-1:0] pc
);
	logic [pcWidth-1:0] stepPc;
	logic [pcWidth-1:0] pcNext;

	assign stepPc = pc + 1'b1;

	always_comb
	begin
		case (pcSel)
			pcJump: pcNext = target;
			pcBranch: pcNext = taken ? pc + {{(pcWidth-immWidth){1'b0}}, imm} : stepPc;
			pcReg: pcNext = regA[pcWidth-1:0];
			default: pcNext = stepPc;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (clearPc)
			pc <= '0;
		else if (!holdPc)
			pc <= pcNext;          // END keeps fetching itself
	end

endmodule

/* source/instructionMemory.sv */
`timescale 1ns/100ps

module instructionMemory import cpuPkg::*;
#(
	parameter int progDepth = 64
)
(
	input  logic clk,
	input  logic progWe,
	input  logic [pcWidth-1:0] progAddr,
	input  instrWord progData,
	input  logic [pcWidth-1:0] pc,
	output instrWord instr
);
	localparam int addrBits = $clog2(progDepth);

	instrWord mem [progDepth];

	always_ff @(posedge clk)
	begin
		if (progWe)
			mem[progAddr[addrBits-1:0]] <= progData;
	end

	assign instr = mem[pc[addrBits-1:0]];   // fetch within the same cycle

endmodule

/* source/dataMemory.sv */
`timescale 1ns/100ps

module dataMemory import cpuPkg::*;
#(
	parameter int dataDepth = 64
)
(
	input  logic clk,
	input  logic memWrite,
	input  logic [pcWidth-1:0] addr,
	input  logic [dataWidth-1:0] writeData,
	output logic [dataWidth-1:0] readData
);
	localparam int addrBits = $clog2(dataDepth);

	logic [dataWidth-1:0] mem [dataDepth];

	always_ff @(posedge clk)
	begin
		if (memWrite)
			mem[addr[addrBits-1:0]] <= writeData;
	end

	assign readData = mem[addr[addrBits-1:0]];

endmodule

/* source/ioPorts.sv */
`timescale 1ns/100ps

module ioPorts import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic portWrite,
	input  logic [regAddrWidth-1:0] inputIndex,
	input  logic [regAddrWidth-1:0] outputIndex,
	input  logic [dataWidth-1:0] writeData,
	input  logic [switchCount-1:0] switches,
	input  logic [buttonCount-1:0] buttons,
	output logic [dataWidth-1:0] inputData,
	output logic [dataWidth-1:0] outPort0,
	output logic [dataWidth-1:0] outPort1,
	output logic [dataWidth-1:0] outPort2
);
	logic [buttonCount-1:0] pressed;
	logic [regAddrWidth-1:0] switchSel;
	logic [1:0] buttonSel;

	assign pressed = ~buttons;     // buttons are active low
	assign switchSel = inputIndex - 5'd1;
	assign buttonSel = 2'(inputIndex - 5'(switchCount + 2));

	// --------------------------------------------------
	// input index decode
	// --------------------------------------------------
	always_comb
	begin
		inputData = '0;
		if (inputIndex == '0)
			inputData = {{(dataWidth-switchCount){1'b0}}, switches};
		else if (inputIndex <= 5'(switchCount))
			inputData = {{(dataWidth-1){1'b0}}, switches[switchSel]};
		else if (inputIndex == 5'(switchCount + 1))
			inputData = {{(dataWidth-buttonCount){1'b0}}, pressed};
		else if (inputIndex <= 5'(switchCount + 1 + buttonCount))
			inputData = {{(dataWidth-1){1'b0}}, pressed[buttonSel]};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outPort0 <= '0;
			outPort1 <= '0;
			outPort2 <= '0;
		end
		else if (portWrite)
		begin
			case (outputIndex)
				5'd0: outPort0 <= writeData;
				5'd1: outPort1 <= writeData;
				5'd2: outPort2 <= writeData;
				default: ;             // no port behind higher indices
			endcase
		end
	end

endmodule

/* source/processor.sv */
`timescale 1ns/100ps

module processor import cpuPkg::*;
#(
	parameter int progDepth = 64,
	parameter int dataDepth = 64
)
(
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic progWe,
	input  logic [pcWidth-1:0] progAddr,
	input  instrWord progData,
	input  logic [switchCount-1:0] switches,
	input  logic [buttonCount-1:0] buttons,
	output logic [dataWidth-1:0] outPort0,
	output logic [dataWidth-1:0] outPort1,
	output logic [dataWidth-1:0] outPort2,
	output logic halted
);
	instrWord instr;
	logic [pcWidth-1:0] pc;
	logic regWrite, memWrite, portWrite, useImm, readRc, holdPc, clearPc;
	logic [aluOpWidth-1:0] aluOp;
	logic [wbSelWidth-1:0] wbSel;
	logic [pcSelWidth-1:0] pcSel;
	logic [regAddrWidth-1:0] readAddrB;
	logic [dataWidth-1:0] regA, regB, aluResult, memData, inputData;

	// branches and STORE read ra as the second source
	assign readAddrB = readRc ? instr.regForm.rc : instr.regForm.ra;

	controlUnit controlUnit0 (.clk, .rst, .run, .opcode(instr.regForm.opcode), .regWrite,
		.memWrite, .portWrite, .useImm, .readRc, .aluOp, .wbSel, .pcSel, .holdPc, .clearPc,
		.halted);

	registerFile registerFile0 (.clk, .regWrite, .wbSel, .writeAddr(instr.regForm.ra),
		.readAddrA(instr.regForm.rb), .readAddrB, .memData, .aluResult, .inputData,
		.longImm(instr.longForm.target), .regA, .regB);

	alu alu0 (.aluOp, .useImm, .regA, .regB, .imm(instr.longForm.target[immWidth-1:0]),
		.aluResult);

	nextPc nextPc0 (.clk, .clearPc, .holdPc, .pcSel, .target(instr.longForm.target),
		.imm(instr.longForm.target[immWidth-1:0]), .regA, .taken(aluResult[0]), .pc);

	instructionMemory #(.progDepth(progDepth)) instructionMemory0 (.clk, .progWe, .progAddr,
		.progData, .pc, .instr);

	dataMemory #(.dataDepth(dataDepth)) dataMemory0 (.clk, .memWrite,
		.addr(instr.longForm.target), .writeData(regB), .readData(memData));

	ioPorts ioPorts0 (.clk, .rst, .portWrite, .inputIndex(instr.regForm.rb),
		.outputIndex(instr.regForm.ra), .writeData(regA), .switches, .buttons, .inputData,
		.outPort0, .outPort1, .outPort2);

endmodule

/* test/processor_assertions.sv */
`timescale 1ns/100ps

module processorAssertions import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic halted,
	input  logic regWrite,
	input  logic memWrite,
	input  logic portWrite,
	input  logic [pcWidth-1:0] pc,
	input  logic [dataWidth-1:0] outPort0,
	input  logic [dataWidth-1:0] outPort1,
	input  logic [dataWidth-1:0] outPort2
);
	// core idle in the cycle after reset
	quietAfterReset: assert property (@(posedge clk)
		rst |=> !halted && !regWrite && !memWrite && !portWrite)
		else $error("halted or a write strobe is high after reset");

	pcHeldWhileHalted: assert property (@(posedge clk) halted |=> $stable(pc))
		else $error("pc moved while the core was halted");

	portsClearedByReset: assert property (@(posedge clk)
		rst |=> outPort0 == '0 && outPort1 == '0 && outPort2 == '0)
		else $error("output ports not zero after reset");

endmodule

/* test/processorTb.sv */
`timescale 1ns/100ps

module processorTb import cpuPkg::*;
();
	localparam int progDepth = 64;
	localparam int dataDepth = 64;
	localparam int programCount = 8;
	localparam int runLimit = 200;
	localparam int cycleLimit = programCount * (runLimit + progDepth + 8);
	// register forms first, then immediate forms, then single-source ops
	localparam logic [opcodeWidth-1:0] aluOps [16] = '{opAdd, opSub, opMult, opAnd, opOr,
		opSlt, opAddI, opSubI, opMultI, opAndI, opOrI, opSltI, opNot, opSll, opSlr, opMove};

	logic clk, rst, run, progWe, halted;
	logic [pcWidth-1:0] progAddr;
	instrWord progData;
	logic [switchCount-1:0] switches;
	logic [buttonCount-1:0] buttons;
	logic [dataWidth-1:0] outPort0, outPort1, outPort2;

	instrWord prog [progDepth];
	int progLen;
	int cycleCount;
	logic [31:0] lcgState;
	logic [dataWidth-1:0] modelRegs [32];
	logic [dataWidth-1:0] modelMem [dataDepth];
	logic [dataWidth-1:0] modelPorts [3];

	processor #(.progDepth(progDepth), .dataDepth(dataDepth)) dut0 (.clk, .rst, .run, .progWe,
		.progAddr, .progData, .switches, .buttons, .outPort0, .outPort1, .outPort2, .halted);

	bind processor processorAssertions assertions0 (.clk, .rst, .halted, .regWrite, .memWrite,
		.portWrite, .pc, .outPort0, .outPort1, .outPort2);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		cycleCount = 0;
		forever
		begin
			@(posedge clk);
			cycleCount++;
			if (cycleCount > cycleLimit)
			begin
				$display("timeout: the run went past %0d cycles", cycleLimit);
				$display("SIMULATION FAILED");
				$fatal(1, "timeout");
			end
		end
	end

	// --------------------------------------------------
	// random numbers and instruction encoding
	// --------------------------------------------------
	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int randomBelow(int n);
		return int'((nextRandom() >> 16) % 32'(n));   // upper bits are the better ones
	endfunction

	function automatic instrWord encodeReg(logic [opcodeWidth-1:0] op, logic [31:0] ra,
		logic [31:0] rb, logic [31:0] rc);
		instrWord w;
		w = '0;
		w.regForm.opcode = op;
		w.regForm.ra = 5'(ra);
		w.regForm.rb = 5'(rb);
		w.regForm.rc = 5'(rc);
		return w;
	endfunction

	function automatic instrWord encodeImm(logic [opcodeWidth-1:0] op, logic [31:0] ra,
		logic [31:0] rb, logic [31:0] imm);
		instrWord w;
		w = '0;
		w.longForm.opcode = op;
		w.longForm.ra = 5'(ra);
		w.longForm.target = {5'(rb), 17'(imm)};   // rb sits above the short immediate
		return w;
	endfunction

	function automatic instrWord encodeLong(logic [opcodeWidth-1:0] op, logic [31:0] ra,
		logic [31:0] target);
		instrWord w;
		w = '0;
		w.longForm.opcode = op;
		w.longForm.ra = 5'(ra);
		w.longForm.target = 22'(target);
		return w;
	endfunction

	task automatic append(instrWord w);
		prog[progLen] = w;
		progLen++;
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic logic [dataWidth-1:0] inputValue(int index);
		logic [buttonCount-1:0] pressed;
		pressed = ~buttons;
		if (index == 0)
			return dataWidth'(switches);
		if (index >= 1 && index <= 18)
			return dataWidth'(switches[index-1]);
		if (index == 19)
			return dataWidth'(pressed);
		if (index >= 20 && index <= 23)
			return dataWidth'(pressed[index-20]);
		return '0;
	endfunction

	task automatic runModel(string name);
		instrWord w;
		logic [pcWidth-1:0] pc;
		logic [pcWidth-1:0] next;
		logic [dataWidth-1:0] a, b, imm;
		int ra, rb, rc, steps;
		logic done;
		pc = '0;
		done = 1'b0;
		steps = 0;
		for (int p = 0; p < 3; p++)
			modelPorts[p] = '0;
		while (!done)
		begin
			if (steps == runLimit)
			begin
				$display("%s: the model did not reach END in %0d steps", name, runLimit);
				$display("SIMULATION FAILED");
				$fatal(1, "model step limit");
			end
			steps++;
			w = prog[int'(pc) % progDepth];
			ra = int'(w.regForm.ra);
			rb = int'(w.regForm.rb);
			rc = int'(w.regForm.rc);
			imm = dataWidth'(w.longForm.target[immWidth-1:0]);
			a = modelRegs[rb];
			b = modelRegs[rc];
			next = pc + 22'd1;
			case (w.regForm.opcode)
				opAdd: modelRegs[ra] = a + b;
				opAddI: modelRegs[ra] = a + imm;
				opSub: modelRegs[ra] = a - b;
				opSubI: modelRegs[ra] = a - imm;
				opMult: modelRegs[ra] = a * b;
				opMultI: modelRegs[ra] = a * imm;
				opAnd: modelRegs[ra] = a & b;
				opAndI: modelRegs[ra] = a & imm;
				opOr: modelRegs[ra] = a | b;
				opOrI: modelRegs[ra] = a | imm;
				opNot: modelRegs[ra] = ~a;
				opSlt: modelRegs[ra] = dataWidth'($signed(a) < $signed(b));
				opSltI: modelRegs[ra] = dataWidth'($signed(a) < $signed(imm));
				opSll: modelRegs[ra] = a << 1;
				opSlr: modelRegs[ra] = a >> 1;
				opMove: modelRegs[ra] = a;
				opSetR: modelRegs[ra] = dataWidth'(w.longForm.target);
				opJ: next = w.longForm.target;
				opJr: next = a[pcWidth-1:0];
				opBeq: if (a == modelRegs[ra]) next = pc + pcWidth'(imm);
				opBnq: if (a != modelRegs[ra]) next = pc + pcWidth'(imm);
				opLoad: modelRegs[ra] = modelMem[int'(w.longForm.target) % dataDepth];
				opStore: modelMem[int'(w.longForm.target) % dataDepth] = modelRegs[ra];
				opInput: modelRegs[ra] = inputValue(rb);
				opOutput: if (ra < 3) modelPorts[ra] = a;
				opEnd: done = 1'b1;
				default: ;
			endcase
			pc = next;
		end
	endtask

	// --------------------------------------------------
	// checks and run sequence
	// --------------------------------------------------
	task automatic checkWord(string name, logic [dataWidth-1:0] expected,
		logic [dataWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic checkFlag(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic checkPorts(string name);
		checkWord({name, " port 0"}, modelPorts[0], outPort0);
		checkWord({name, " port 1"}, modelPorts[1], outPort1);
		checkWord({name, " port 2"}, modelPorts[2], outPort2);
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic resetCore();
		rst = 1'b1;
		repeat (2) stepCycle();
		rst = 1'b0;
	endtask

	task automatic runProgram(string name);
		run = 1'b0;
		resetCore();                   // stop the old program before overwriting it
		for (int i = 0; i < progLen; i++)
		begin
			progWe = 1'b1;
			progAddr = pcWidth'(i);
			progData = prog[i];
			stepCycle();
		end
		progWe = 1'b0;
		resetCore();
		checkFlag({name, " halted before run"}, 1'b0, halted);
		checkWord({name, " port 0 before run"}, '0, outPort0);
		checkWord({name, " port 1 before run"}, '0, outPort1);
		checkWord({name, " port 2 before run"}, '0, outPort2);
		runModel(name);
		run = 1'b1;
		while (!halted)
			stepCycle();
		checkPorts(name);
		repeat (10)
		begin
			stepCycle();
			checkFlag({name, " halted after END"}, 1'b1, halted);
			checkPorts({name, " after END"});
		end
		run = 1'b0;
	endtask

	// --------------------------------------------------
	// program generators
	// --------------------------------------------------
	task automatic buildAluProgram();
		instrWord w;
		int k;
		progLen = 0;
		for (int r = 1; r <= 6; r++)
			append(encodeLong(opSetR, r, nextRandom()));
		for (int i = 0; i < 14; i++)
		begin
			k = randomBelow(16);
			w = encodeImm(aluOps[k], 1 + randomBelow(6), 1 + randomBelow(6), nextRandom());
			if (k < 6)
				w.regForm.rc = 5'(1 + randomBelow(6));   // register forms need a live rc
			append(w);
		end
		for (int p = 0; p < 3; p++)
			append(encodeReg(opOutput, p, 1 + randomBelow(6), 0));
		append(encodeReg(opEnd, 0, 0, 0));
	endtask

	task automatic buildInputProgram();
		progLen = 0;
		switches = switchCount'(nextRandom() >> 8);
		buttons = buttonCount'(nextRandom() >> 12);
		for (int p = 0; p < 3; p++)
			append(encodeReg(opInput, p + 1, randomBelow(24), 0));
		for (int p = 0; p < 3; p++)
			append(encodeReg(opOutput, p, p + 1, 0));
		append(encodeReg(opEnd, 0, 0, 0));
	endtask

	task automatic buildMemoryProgram();
		int addr [3];
		progLen = 0;
		addr[0] = randomBelow(dataDepth);
		addr[1] = (addr[0] + 1 + randomBelow(20)) % dataDepth;
		addr[2] = (addr[1] + 1 + randomBelow(20)) % dataDepth;   // all three distinct
		for (int r = 1; r <= 3; r++)
			append(encodeLong(opSetR, r, nextRandom()));
		append(encodeReg(opMult, 1, 1, 2));   // fills the upper bits too
		for (int i = 0; i < 3; i++)
			append(encodeLong(opStore, i + 1, addr[i]));
		for (int i = 0; i < 3; i++)
			append(encodeLong(opLoad, i + 4, addr[i]));
		for (int i = 0; i < 3; i++)
			append(encodeReg(opOutput, i, i + 4, 0));
		append(encodeReg(opEnd, 0, 0, 0));
	endtask

	task automatic buildPowerProgram();
		progLen = 0;
		append(encodeLong(opSetR, 1, 2 + randomBelow(6)));    // base
		append(encodeLong(opSetR, 2, randomBelow(6)));        // exponent
		append(encodeLong(opSetR, 3, 1));
		append(encodeLong(opSetR, 4, 0));
		append(encodeImm(opBeq, 4, 2, 4));                    // exponent spent, leave loop
		append(encodeReg(opMult, 3, 3, 1));
		append(encodeImm(opSubI, 2, 2, 1));
		append(encodeLong(opJ, 0, 4));
		append(encodeReg(opOutput, 0, 3, 0));
		append(encodeLong(opSetR, 5, 12));
		append(encodeReg(opJr, 0, 5, 0));
		append(encodeLong(opSetR, 5, 0));                     // skipped by JR
		append(encodeLong(opSetR, 6, nextRandom() | 32'h0020_0000));
		append(encodeImm(opBnq, 6, 6, 2));                    // equal, falls through
		append(encodeReg(opOutput, 1, 6, 0));
		append(encodeImm(opBnq, 3, 6, 2));
		append(encodeLong(opSetR, 5, 1));                     // skipped by BNQ
		append(encodeReg(opOutput, 2, 5, 0));                 // r5 still holds the JR target
		append(encodeReg(opEnd, 0, 0, 0));
	endtask

	initial
	begin
		lcgState = 32'h021e_5ed8;
		rst = 1'b1;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		switches = '0;
		buttons = '1;
		progLen = 0;
		for (int t = 0; t < 3; t++)
		begin
			buildAluProgram();
			runProgram($sformatf("alu %0d", t));
		end
		for (int t = 0; t < 2; t++)
		begin
			buildInputProgram();
			runProgram($sformatf("input %0d", t));
		end
		for (int t = 0; t < 2; t++)
		begin
			buildMemoryProgram();
			runProgram($sformatf("memory %0d", t));
		end
		buildPowerProgram();
		runProgram("power loop");
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* sim.f */
common/cpuPkg.sv
core/controlUnit.sv
core/alu.sv
core/registerFile.sv
core/nextPc.sv
source/instructionMemory.sv
source/dataMemory.sv
source/ioPorts.sv
source/processor.sv
test/processor_assertions.sv
test/processorTb.sv

/* run.sh */
#!/bin/sh
# build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module processorTb \
	-Mdir obj_dir -o processorSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/processorSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
